// File: Makefile
VERILATOR ?= verilator
FILELIST ?= tb.f
TOP ?= battle_tb
RTL_TOP ?= pet_battle_top
BUILD_DIR ?= obj_dir
VFLAGS ?=
PASS_MSG ?= ALL TESTS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)

sim: build
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: include/battle_macros.svh
`ifndef BATTLE_MACROS_SVH
`define BATTLE_MACROS_SVH

// Pet record sizes
`define BATTLE_STAT_W 3
`define BATTLE_PETS 4
`define BATTLE_LIVES_W 3

// Random source
`define BATTLE_RNG_W 8
`define BATTLE_RNG_SEED 8'hA5
`define BATTLE_RNG_TAPS 8'hB8
`define BATTLE_WARMUP 8

// Key codes
`define BATTLE_KEY_W 5
`define BATTLE_KEY_GEN 14
`define BATTLE_KEY_PREV 9
`define BATTLE_KEY_NEXT 10
`define BATTLE_KEY_CONFIRM 13

// Select keys, one per pet, counted up from the base
`define BATTLE_KEY_P1_BASE 1
`define BATTLE_KEY_P2_BASE 5

`endif

// File: logic/battle_fsm.sv
`timescale 1ns/10ps
`include "battle_macros.svh"

module battle_fsm (
	input logic clk,
	input logic reset,
	input logic key_valid,
	input logic [`BATTLE_KEY_W-1:0] key_code,
	input logic ready,
	input logic done,
	output logic gen,
	output logic act_toggle,
	output logic act_confirm,
	output battle_pkg::player_t act_player,
	output battle_pkg::phase_t phase,
	output logic game_over,
	output battle_pkg::player_t winner,
	select_if.fsm sel,
	combat_if.monitor cmb
);

	logic is_gen;
	logic is_toggle;
	logic is_confirm;
	logic is_p1_key;
	logic is_p2_key;
	logic [`BATTLE_KEY_W-1:0] p1_off;
	logic [`BATTLE_KEY_W-1:0] p2_off;
	logic sel_p1_phase;
	logic sel_p2_phase;
	logic turn_phase;
	battle_pkg::player_t turn_player;
	battle_pkg::player_t victim;
	logic [`BATTLE_LIVES_W-1:0] victim_lives;
	logic [`BATTLE_STAT_W-1:0] victim_hp;
	battle_pkg::phase_t phase_next;

	// Key classes
	assign is_gen = (key_code == `BATTLE_KEY_GEN);
	assign is_toggle = (key_code == `BATTLE_KEY_PREV) || (key_code == `BATTLE_KEY_NEXT);
	assign is_confirm = (key_code == `BATTLE_KEY_CONFIRM);
	assign is_p1_key = (key_code >= `BATTLE_KEY_P1_BASE)
		&& (key_code < `BATTLE_KEY_P1_BASE + `BATTLE_PETS);
	assign is_p2_key = (key_code >= `BATTLE_KEY_P2_BASE)
		&& (key_code < `BATTLE_KEY_P2_BASE + `BATTLE_PETS);
	assign p1_off = key_code - `BATTLE_KEY_P1_BASE;
	assign p2_off = key_code - `BATTLE_KEY_P2_BASE;

	assign sel_p1_phase = (phase == battle_pkg::PH_SELECT_P1)
		|| (phase == battle_pkg::PH_RESELECT_P1);
	assign sel_p2_phase = (phase == battle_pkg::PH_SELECT_P2)
		|| (phase == battle_pkg::PH_RESELECT_P2);
	assign turn_phase = (phase == battle_pkg::PH_TURN_P1) || (phase == battle_pkg::PH_TURN_P2);

	// Strobes out
	assign gen = key_valid && is_gen && (phase == battle_pkg::PH_GENERATE) && !done;
	assign sel.valid = key_valid && ((sel_p1_phase && is_p1_key) || (sel_p2_phase && is_p2_key));
	assign sel.player = sel_p2_phase ? battle_pkg::PLAYER_2 : battle_pkg::PLAYER_1;
	assign sel.index = sel_p2_phase ? p2_off[1:0] : p1_off[1:0];
	assign act_toggle = key_valid && is_toggle && turn_phase;
	assign act_confirm = key_valid && is_confirm && turn_phase;
	assign act_player = (phase == battle_pkg::PH_TURN_P2) ? battle_pkg::PLAYER_2
		: battle_pkg::PLAYER_1;

	// The victim of a resolve is whoever did not just play
	assign victim = (turn_player == battle_pkg::PLAYER_1) ? battle_pkg::PLAYER_2
		: battle_pkg::PLAYER_1;
	assign victim_lives = (victim == battle_pkg::PLAYER_1) ? cmb.p1_lives : cmb.p2_lives;
	assign victim_hp = (victim == battle_pkg::PLAYER_1) ? cmb.p1_active.hp : cmb.p2_active.hp;

	assign game_over = (phase == battle_pkg::PH_VICTORY);

	always_comb begin
		phase_next = phase;
		case (phase)
			battle_pkg::PH_WARMUP:
				if (ready)
					phase_next = battle_pkg::PH_GENERATE;
			battle_pkg::PH_GENERATE:
				if (done)
					phase_next = battle_pkg::PH_SELECT_P1;
			battle_pkg::PH_SELECT_P1:
				if (sel.valid && sel.ok)
					phase_next = battle_pkg::PH_SELECT_P2;
			// Both lead into player 1's turn
			battle_pkg::PH_SELECT_P2, battle_pkg::PH_RESELECT_P1:
				if (sel.valid && sel.ok)
					phase_next = battle_pkg::PH_TURN_P1;
			battle_pkg::PH_RESELECT_P2:
				if (sel.valid && sel.ok)
					phase_next = battle_pkg::PH_TURN_P2;
			battle_pkg::PH_TURN_P1, battle_pkg::PH_TURN_P2:
				if (act_confirm)
					phase_next = battle_pkg::PH_RESOLVE;
			battle_pkg::PH_RESOLVE: begin
				if (victim_lives == '0)
					phase_next = battle_pkg::PH_VICTORY;
				else if (victim_hp == '0)
					phase_next = (victim == battle_pkg::PLAYER_1) ? battle_pkg::PH_RESELECT_P1
						: battle_pkg::PH_RESELECT_P2;
				else
					phase_next = (victim == battle_pkg::PLAYER_1) ? battle_pkg::PH_TURN_P1
						: battle_pkg::PH_TURN_P2;
			end
			default:
				phase_next = phase;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= battle_pkg::PH_WARMUP;
			turn_player <= battle_pkg::PLAYER_1;
			winner <= battle_pkg::PLAYER_1;
		end else begin
			phase <= phase_next;
			if (act_confirm)
				turn_player <= act_player;
			if (phase == battle_pkg::PH_RESOLVE && victim_lives == '0)
				winner <= turn_player;
		end
	end

endmodule

// File: logic/battle_ifs.sv
`timescale 1ns/10ps
`include "battle_macros.svh"

// One roster slot write per valid cycle
interface pet_write_if;
	logic valid;
	battle_pkg::player_t player;
	battle_pkg::pet_index_t index;
	battle_pkg::pet_stats_t stats;

	modport source (output valid, output player, output index, output stats);
	modport sink (input valid, input player, input index, input stats);
endinterface

// Active pet request, ok comes back in the same cycle
interface select_if;
	logic valid;
	battle_pkg::player_t player;
	battle_pkg::pet_index_t index;
	logic ok;

	modport fsm (output valid, output player, output index, input ok);
	modport roster (input valid, input player, input index, output ok);
endinterface

interface combat_if;
	logic hit_valid;
	battle_pkg::player_t hit_player;
	logic [`BATTLE_STAT_W-1:0] hit_damage;
	battle_pkg::pet_stats_t p1_active;
	battle_pkg::pet_stats_t p2_active;
	logic [`BATTLE_LIVES_W-1:0] p1_lives;
	logic [`BATTLE_LIVES_W-1:0] p2_lives;

	modport roster (
		input hit_valid, input hit_player, input hit_damage,
		output p1_active, output p2_active, output p1_lives, output p2_lives
	);
	modport combat (
		output hit_valid, output hit_player, output hit_damage,
		input p1_active, input p2_active
	);
	modport monitor (
		input hit_valid, input hit_player, input hit_damage,
		input p1_active, input p2_active, input p1_lives, input p2_lives
	);
endinterface

// File: logic/battle_pkg.sv
`include "battle_macros.svh"

package battle_pkg;

	// Bit order follows the old 9-bit record, atk on top
	typedef struct packed {
		logic [`BATTLE_STAT_W-1:0] atk;
		logic [`BATTLE_STAT_W-1:0] def;
		logic [`BATTLE_STAT_W-1:0] hp;
	} pet_stats_t;

	typedef enum logic {
		PLAYER_1,
		PLAYER_2
	} player_t;

	typedef logic [1:0] pet_index_t;

	typedef enum logic {
		ACT_ATTACK,
		ACT_DEFEND
	} action_t;

	typedef enum logic [3:0] {
		PH_WARMUP,
		PH_GENERATE,
		PH_SELECT_P1,
		PH_SELECT_P2,
		PH_TURN_P1,
		PH_TURN_P2,
		PH_RESOLVE,
		PH_RESELECT_P1,
		PH_RESELECT_P2,
		PH_VICTORY
	} phase_t;

endpackage

// File: logic/combat_unit.sv
`timescale 1ns/10ps
`include "battle_macros.svh"

module combat_unit (
	input logic clk,
	input logic reset,
	input logic act_toggle,
	input logic act_confirm,
	input battle_pkg::player_t act_player,
	combat_if.combat cmb
);

	battle_pkg::action_t action [2];
	logic blocking [2];
	battle_pkg::player_t opponent;
	battle_pkg::pet_stats_t attacker_pet;
	battle_pkg::pet_stats_t defender_pet;
	logic [`BATTLE_STAT_W-1:0] damage;

	assign opponent = (act_player == battle_pkg::PLAYER_1) ? battle_pkg::PLAYER_2
		: battle_pkg::PLAYER_1;
	assign attacker_pet = (act_player == battle_pkg::PLAYER_1) ? cmb.p1_active : cmb.p2_active;
	assign defender_pet = (act_player == battle_pkg::PLAYER_1) ? cmb.p2_active : cmb.p1_active;

	always_comb begin
		if (action[act_player] == battle_pkg::ACT_DEFEND)
			damage = '0;
		else if (!blocking[opponent])
			damage = attacker_pet.atk;
		else if (attacker_pet.atk > defender_pet.def)
			damage = attacker_pet.atk - defender_pet.def;
		else
			damage = '0;
	end

	// Every confirm hits the opponent, a defend simply hits for zero
	assign cmb.hit_valid = act_confirm;
	assign cmb.hit_player = opponent;
	assign cmb.hit_damage = damage;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int p = 0; p < 2; p++) begin
				action[p] <= battle_pkg::ACT_ATTACK;
				blocking[p] <= 1'b0;
			end
		end else if (act_toggle) begin
			action[act_player] <= (action[act_player] == battle_pkg::ACT_ATTACK)
				? battle_pkg::ACT_DEFEND : battle_pkg::ACT_ATTACK;
		end else if (act_confirm) begin
			// Block lasts until this player's next confirm
			blocking[act_player] <= (action[act_player] == battle_pkg::ACT_DEFEND);
		end
	end

endmodule

// File: logic/lfsr_rng.sv
`timescale 1ns/10ps
`include "battle_macros.svh"

module lfsr_rng (
	input logic clk,
	input logic reset,
	input logic step,
	output logic [`BATTLE_RNG_W-1:0] value
);

	logic [`BATTLE_RNG_W-1:0] shifted;

	// Galois form, shift right and fold the taps in when a one drops out
	always_comb begin
		shifted = value >> 1;
		if (value[0])
			shifted = shifted ^ `BATTLE_RNG_TAPS;
	end

	always_ff @(posedge clk) begin
		if (reset)
			value <= `BATTLE_RNG_SEED;
		else if (step)
			value <= shifted;
	end

endmodule

// File: logic/pet_battle_top.sv
`timescale 1ns/10ps
`include "battle_macros.svh"

module pet_battle_top (
	input logic clk,
	input logic reset,
	input logic key_valid,
	input logic [`BATTLE_KEY_W-1:0] key_code,
	output battle_pkg::phase_t phase,
	output battle_pkg::pet_stats_t p1_active,
	output battle_pkg::pet_stats_t p2_active,
	output logic [`BATTLE_LIVES_W-1:0] p1_lives,
	output logic [`BATTLE_LIVES_W-1:0] p2_lives,
	output logic game_over,
	output battle_pkg::player_t winner
);

	logic [`BATTLE_RNG_W-1:0] random;
	logic step;
	logic ready;
	logic done;
	logic gen;
	logic act_toggle;
	logic act_confirm;
	battle_pkg::player_t act_player;

	pet_write_if wr_bus ();
	select_if sel_bus ();
	combat_if cmb_bus ();

	lfsr_rng u_rng (
		.clk(clk),
		.reset(reset),
		.step(step),
		.value(random)
	);

	pet_generator u_gen (
		.clk(clk),
		.reset(reset),
		.gen(gen),
		.random(random),
		.step(step),
		.ready(ready),
		.done(done),
		.wr(wr_bus.source)
	);

	pet_roster u_roster (
		.clk(clk),
		.reset(reset),
		.wr(wr_bus.sink),
		.sel(sel_bus.roster),
		.cmb(cmb_bus.roster)
	);

	combat_unit u_combat (
		.clk(clk),
		.reset(reset),
		.act_toggle(act_toggle),
		.act_confirm(act_confirm),
		.act_player(act_player),
		.cmb(cmb_bus.combat)
	);

	battle_fsm u_fsm (
		.clk(clk),
		.reset(reset),
		.key_valid(key_valid),
		.key_code(key_code),
		.ready(ready),
		.done(done),
		.gen(gen),
		.act_toggle(act_toggle),
		.act_confirm(act_confirm),
		.act_player(act_player),
		.phase(phase),
		.game_over(game_over),
		.winner(winner),
		.sel(sel_bus.fsm),
		.cmb(cmb_bus.monitor)
	);

	// Status straight off the combat bus
	assign p1_active = cmb_bus.p1_active;
	assign p2_active = cmb_bus.p2_active;
	assign p1_lives = cmb_bus.p1_lives;
	assign p2_lives = cmb_bus.p2_lives;

endmodule

// File: logic/pet_generator.sv
`timescale 1ns/10ps
`include "battle_macros.svh"

module pet_generator (
	input logic clk,
	input logic reset,
	input logic gen,
	input logic [`BATTLE_RNG_W-1:0] random,
	output logic step,
	output logic ready,
	output logic done,
	pet_write_if.source wr
);

	logic [$clog2(`BATTLE_WARMUP + 1)-1:0] warm_cnt;
	logic warming;
	logic [2:0] slot;

	assign warming = (warm_cnt != `BATTLE_WARMUP);
	assign ready = !warming;

	// The RNG runs freely during warm-up, then only once per pet written
	assign step = warming || gen;

	// Zero fields would give a dead or defenceless pet, so they become 1
	assign wr.valid = gen;
	assign wr.player = slot[2] ? battle_pkg::PLAYER_2 : battle_pkg::PLAYER_1;
	assign wr.index = slot[1:0];
	assign wr.stats.hp = (random[2:0] == 3'd0) ? 3'd1 : random[2:0];
	assign wr.stats.def = (random[5:3] == 3'd0) ? 3'd1 : random[5:3];
	assign wr.stats.atk = {1'b1, random[7:6]};

	always_ff @(posedge clk) begin
		if (reset) begin
			warm_cnt <= '0;
			slot <= '0;
			done <= 1'b0;
		end else begin
			if (warming)
				warm_cnt <= warm_cnt + 1'b1;
			if (gen) begin
				slot <= slot + 3'd1;
				if (slot == 3'd7)
					done <= 1'b1;
			end
		end
	end

endmodule

// File: logic/pet_roster.sv
`timescale 1ns/10ps
`include "battle_macros.svh"

module pet_roster (
	input logic clk,
	input logic reset,
	pet_write_if.sink wr,
	select_if.roster sel,
	combat_if.roster cmb
);

	battle_pkg::pet_stats_t pets [2][`BATTLE_PETS];
	battle_pkg::pet_index_t active [2];
	logic [`BATTLE_LIVES_W-1:0] lives [2];
	logic [`BATTLE_STAT_W-1:0] victim_hp;
	logic [`BATTLE_STAT_W-1:0] victim_hp_next;

	// A pet with no health left cannot be picked
	assign sel.ok = (pets[sel.player][sel.index].hp != '0);

	assign cmb.p1_active = pets[battle_pkg::PLAYER_1][active[battle_pkg::PLAYER_1]];
	assign cmb.p2_active = pets[battle_pkg::PLAYER_2][active[battle_pkg::PLAYER_2]];
	assign cmb.p1_lives = lives[battle_pkg::PLAYER_1];
	assign cmb.p2_lives = lives[battle_pkg::PLAYER_2];

	// Health saturates at zero
	assign victim_hp = pets[cmb.hit_player][active[cmb.hit_player]].hp;
	assign victim_hp_next = (victim_hp > cmb.hit_damage) ? victim_hp - cmb.hit_damage : '0;

	always_comb begin
		for (int p = 0; p < 2; p++) begin
			lives[p] = '0;
			for (int i = 0; i < `BATTLE_PETS; i++) begin
				if (pets[p][i].hp != '0)
					lives[p] = lives[p] + 1'b1;
			end
		end
	end

	// Pet records
	always_ff @(posedge clk) begin
		if (wr.valid)
			pets[wr.player][wr.index] <= wr.stats;
		if (cmb.hit_valid)
			pets[cmb.hit_player][active[cmb.hit_player]].hp <= victim_hp_next;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			active[battle_pkg::PLAYER_1] <= '0;
			active[battle_pkg::PLAYER_2] <= '0;
		end else if (sel.valid && sel.ok) begin
			active[sel.player] <= sel.index;
		end
	end

endmodule

// File: tb.f
+incdir+include
logic/battle_pkg.sv
logic/battle_ifs.sv
logic/lfsr_rng.sv
logic/pet_generator.sv
logic/pet_roster.sv
logic/combat_unit.sv
logic/battle_fsm.sv
logic/pet_battle_top.sv
verification/battle_tb.sv

// File: verification/battle_tb.sv
`timescale 1ns/10ps
`include "battle_macros.svh"

module battle_tb;

	localparam int KEY_GAP = 6;
	localparam int COMBAT_BUDGET = 200;
	localparam int MAX_KEYS = 240;
	localparam int TIMEOUT_CYCLES = 2 * (MAX_KEYS * (KEY_GAP + 2) + 60);

	logic clk;
	logic reset;
	logic key_valid;
	logic [`BATTLE_KEY_W-1:0] key_code;
	battle_pkg::phase_t phase;
	battle_pkg::pet_stats_t p1_active;
	battle_pkg::pet_stats_t p2_active;
	logic [`BATTLE_LIVES_W-1:0] p1_lives;
	logic [`BATTLE_LIVES_W-1:0] p2_lives;
	logic game_over;
	battle_pkg::player_t winner;

	// Game model, index 0 is player 1
	battle_pkg::phase_t m_phase;
	logic [7:0] m_rng;
	int m_slot;
	int m_atk [2][`BATTLE_PETS];
	int m_def [2][`BATTLE_PETS];
	int m_hp [2][`BATTLE_PETS];
	int m_active [2];
	int m_sel [2];
	int m_action [2];
	int m_block [2];
	int m_winner;

	logic [31:0] rng_state;
	int keys_sent = 0;
	int keys_checked = 0;
	int errors = 0;
	int checks = 0;

	pet_battle_top DUT (
		.clk(clk),
		.reset(reset),
		.key_valid(key_valid),
		.key_code(key_code),
		.phase(phase),
		.p1_active(p1_active),
		.p2_active(p2_active),
		.p1_lives(p1_lives),
		.p2_lives(p2_lives),
		.game_over(game_over),
		.winner(winner)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic int rand_below(input int n);
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return int'(rng_state % 32'(n));
	endfunction

	// Galois step, taps folded in when a one falls out
	function automatic logic [7:0] lfsr_next(input logic [7:0] v);
		return v[0] ? ({1'b0, v[7:1]} ^ `BATTLE_RNG_TAPS) : {1'b0, v[7:1]};
	endfunction

	function automatic int stat_hp(input logic [7:0] r);
		return (r[2:0] == 3'd0) ? 1 : int'(r[2:0]);
	endfunction

	function automatic int stat_def(input logic [7:0] r);
		return (r[5:3] == 3'd0) ? 1 : int'(r[5:3]);
	endfunction

	function automatic int stat_atk(input logic [7:0] r);
		return 4 + int'(r[7:6]);
	endfunction

	function automatic int damage_ref(input int atk, input int def, input int blocking);
		if (blocking == 0)
			return atk;
		return (atk > def) ? atk - def : 0;
	endfunction

	function automatic int live_count(input int p);
		int n;
		n = 0;
		for (int i = 0; i < `BATTLE_PETS; i++) begin
			if (m_hp[p][i] != 0)
				n++;
		end
		return n;
	endfunction

	function automatic logic [8:0] pet_word(input int p, input int i);
		return {3'(m_atk[p][i]), 3'(m_def[p][i]), 3'(m_hp[p][i])};
	endfunction

	function automatic int pick_live(input int p);
		int start;
		int idx;
		start = rand_below(`BATTLE_PETS);
		for (int k = 0; k < `BATTLE_PETS; k++) begin
			idx = (start + k) % `BATTLE_PETS;
			if (m_hp[p][idx] != 0)
				return idx;
		end
		return start;
	endfunction

	function automatic int pick_distractor();
		case (rand_below(3))
			0: return `BATTLE_KEY_CONFIRM;
			1: return `BATTLE_KEY_P1_BASE + rand_below(`BATTLE_PETS);
			default: return `BATTLE_KEY_P2_BASE + rand_below(`BATTLE_PETS);
		endcase
	endfunction

	task automatic model_reset();
		m_phase = battle_pkg::PH_WARMUP;
		m_rng = `BATTLE_RNG_SEED;
		repeat (`BATTLE_WARMUP) m_rng = lfsr_next(m_rng);
		m_slot = 0;
		m_winner = 0;
		for (int p = 0; p < 2; p++) begin
			m_active[p] = 0;
			m_sel[p] = 0;
			m_action[p] = 0;
			m_block[p] = 0;
			for (int i = 0; i < `BATTLE_PETS; i++) begin
				m_atk[p][i] = 0;
				m_def[p][i] = 0;
				m_hp[p][i] = 0;
			end
		end
	endtask

	task automatic model_key(input int code);
		int p;
		int opp;
		int idx;
		int dmg;
		int hp;
		case (m_phase)
			battle_pkg::PH_GENERATE: begin
				if (code == `BATTLE_KEY_GEN && m_slot < 2 * `BATTLE_PETS) begin
					p = m_slot / `BATTLE_PETS;
					idx = m_slot % `BATTLE_PETS;
					m_hp[p][idx] = stat_hp(m_rng);
					m_def[p][idx] = stat_def(m_rng);
					m_atk[p][idx] = stat_atk(m_rng);
					m_rng = lfsr_next(m_rng);
					m_slot++;
					if (m_slot == 2 * `BATTLE_PETS)
						m_phase = battle_pkg::PH_SELECT_P1;
				end
			end
			battle_pkg::PH_SELECT_P1, battle_pkg::PH_RESELECT_P1: begin
				idx = code - `BATTLE_KEY_P1_BASE;
				if (idx >= 0 && idx < `BATTLE_PETS && m_hp[0][idx] != 0) begin
					m_active[0] = idx;
					m_sel[0] = 1;
					m_phase = (m_phase == battle_pkg::PH_SELECT_P1) ? battle_pkg::PH_SELECT_P2
						: battle_pkg::PH_TURN_P1;
				end
			end
			battle_pkg::PH_SELECT_P2, battle_pkg::PH_RESELECT_P2: begin
				idx = code - `BATTLE_KEY_P2_BASE;
				if (idx >= 0 && idx < `BATTLE_PETS && m_hp[1][idx] != 0) begin
					m_active[1] = idx;
					m_sel[1] = 1;
					m_phase = (m_phase == battle_pkg::PH_SELECT_P2) ? battle_pkg::PH_TURN_P1
						: battle_pkg::PH_TURN_P2;
				end
			end
			battle_pkg::PH_TURN_P1, battle_pkg::PH_TURN_P2: begin
				p = (m_phase == battle_pkg::PH_TURN_P2) ? 1 : 0;
				opp = 1 - p;
				if (code == `BATTLE_KEY_PREV || code == `BATTLE_KEY_NEXT) begin
					m_action[p] = 1 - m_action[p];
				end else if (code == `BATTLE_KEY_CONFIRM) begin
					// A defend still resolves, with no damage
					if (m_action[p] != 0)
						dmg = 0;
					else
						dmg = damage_ref(m_atk[p][m_active[p]], m_def[opp][m_active[opp]],
							m_block[opp]);
					hp = m_hp[opp][m_active[opp]];
					m_hp[opp][m_active[opp]] = (hp > dmg) ? hp - dmg : 0;
					m_block[p] = m_action[p];
					if (live_count(opp) == 0) begin
						m_phase = battle_pkg::PH_VICTORY;
						m_winner = p;
					end else if (m_hp[opp][m_active[opp]] == 0) begin
						m_phase = (opp != 0) ? battle_pkg::PH_RESELECT_P2
							: battle_pkg::PH_RESELECT_P1;
					end else begin
						m_phase = (opp != 0) ? battle_pkg::PH_TURN_P2 : battle_pkg::PH_TURN_P1;
					end
				end
			end
			default: begin
			end
		endcase
	endtask

	task automatic check_value(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error at %0d ns: %s is %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	task automatic compare_state();
		check_value("phase", 32'(phase), 32'(m_phase));
		check_value("game_over", 32'(game_over), (m_phase == battle_pkg::PH_VICTORY) ? 1 : 0);
		if (m_slot == 2 * `BATTLE_PETS) begin
			check_value("p1_lives", 32'(p1_lives), live_count(0));
			check_value("p2_lives", 32'(p2_lives), live_count(1));
		end
		if (m_sel[0] != 0)
			check_value("p1_active", 32'(p1_active), 32'(pet_word(0, m_active[0])));
		if (m_sel[1] != 0)
			check_value("p2_active", 32'(p2_active), 32'(pet_word(1, m_active[1])));
		if (m_phase == battle_pkg::PH_VICTORY)
			check_value("winner", 32'(winner), m_winner);
	endtask

	task automatic send_key(input int code);
		@(posedge clk);
		#1;
		key_valid = 1'b1;
		key_code = 5'(code);
		model_key(code);
		keys_sent++;
		@(posedge clk);
		#1;
		key_valid = 1'b0;
		key_code = '0;
		repeat (KEY_GAP) @(posedge clk);
	endtask

	// Outputs settle well within four cycles of a key
	initial begin : compare_outputs
		forever begin
			wait (keys_checked != keys_sent);
			repeat (4) @(posedge clk);
			@(negedge clk);
			compare_state();
			keys_checked++;
		end
	end

	initial begin : stimulus
		int p;
		int base;
		int combat_keys;
		int faints;
		combat_keys = 0;
		faints = 0;
		rng_state = 32'd46514;
		reset = 1'b1;
		key_valid = 1'b0;
		key_code = '0;
		model_reset();

		repeat (3) @(posedge clk);
		@(negedge clk);
		check_value("phase in reset", 32'(phase), 32'(battle_pkg::PH_WARMUP));
		check_value("game_over in reset", 32'(game_over), 0);
		repeat (7) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		check_value("phase after reset", 32'(phase), 32'(battle_pkg::PH_WARMUP));
		repeat (20) @(posedge clk);
		@(negedge clk);
		check_value("phase after warm-up", 32'(phase), 32'(battle_pkg::PH_GENERATE));
		m_phase = battle_pkg::PH_GENERATE;

		// Generation with stray keys mixed in, plus one generate too many
		for (int k = 0; k < 2 * `BATTLE_PETS; k++) begin
			send_key(pick_distractor());
			send_key(`BATTLE_KEY_GEN);
		end
		send_key(`BATTLE_KEY_GEN);

		send_key(`BATTLE_KEY_P2_BASE + rand_below(`BATTLE_PETS));
		send_key(`BATTLE_KEY_P1_BASE + rand_below(`BATTLE_PETS));
		send_key(`BATTLE_KEY_P1_BASE + rand_below(`BATTLE_PETS));
		send_key(`BATTLE_KEY_P2_BASE + rand_below(`BATTLE_PETS));

		while (m_phase != battle_pkg::PH_VICTORY && combat_keys < COMBAT_BUDGET) begin
			if (m_phase == battle_pkg::PH_TURN_P1 || m_phase == battle_pkg::PH_TURN_P2) begin
				p = (m_phase == battle_pkg::PH_TURN_P2) ? 1 : 0;
				// Mostly attack, a defender usually switches back
				if (rand_below(4) < ((m_action[p] != 0) ? 3 : 1)) begin
					send_key((rand_below(2) != 0) ? `BATTLE_KEY_NEXT : `BATTLE_KEY_PREV);
					combat_keys++;
				end
				send_key(`BATTLE_KEY_CONFIRM);
				combat_keys++;
			end else if (m_phase == battle_pkg::PH_RESELECT_P1
				|| m_phase == battle_pkg::PH_RESELECT_P2) begin
				p = (m_phase == battle_pkg::PH_RESELECT_P2) ? 1 : 0;
				base = (p != 0) ? `BATTLE_KEY_P2_BASE : `BATTLE_KEY_P1_BASE;
				faints++;
				// The fainted pet first, which must be refused
				send_key(base + m_active[p]);
				send_key(base + pick_live(p));
				combat_keys += 2;
			end else begin
				errors++;
				$display("combat reached a phase where no key can be chosen");
				break;
			end
		end
		if (m_phase != battle_pkg::PH_VICTORY) begin
			errors++;
			$display("the game did not end within %0d combat keys", COMBAT_BUDGET);
		end
		if (faints == 0) begin
			errors++;
			$display("no pet fainted before the end of the game");
		end

		send_key(`BATTLE_KEY_CONFIRM);
		send_key(`BATTLE_KEY_P1_BASE + rand_below(`BATTLE_PETS));
		send_key(`BATTLE_KEY_GEN);

		wait (keys_checked == keys_sent);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
